/* design/uart_link_pkg.sv */
`default_nettype none

package uart_link_pkg;

  // ##########################################################################
  // command and frame widths
  // ##########################################################################
  localparam int CMD_WIDTH  = 16;
  localparam int DATA_WIDTH = 8;
  localparam int ADDR_WIDTH = 7;

  // command bit 15
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cmd_op_e;

  // ##########################################################################
  // state encodings
  // ##########################################################################
  typedef enum logic [2:0] {
    ENG_IDLE,
    ENG_SEND_HI,
    ENG_GAP,
    ENG_SEND_LO,
    ENG_WAIT_RESP,
    ENG_RESPOND
  } engine_state_e;

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_PARITY,
    TX_STOP
  } tx_state_e;

endpackage

`default_nettype wire

/* design/cmd_port.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_port #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               cmd_vld,
  input  logic [uart_link_pkg::CMD_WIDTH-1:0] cmd,
  input  logic                               pop,
  output logic                               credit,
  output logic                               head_vld,
  output logic [uart_link_pkg::CMD_WIDTH-1:0] head_cmd
);

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  logic [uart_link_pkg::CMD_WIDTH-1:0] mem [QUEUE_DEPTH];
  logic [PTR_W-1:0]                    wr_ptr;
  logic [PTR_W-1:0]                    rd_ptr;
  logic [CNT_W-1:0]                    count;
  logic                                full;

  // wraps for depths that are not a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full     = count == CNT_W'(QUEUE_DEPTH);
  assign head_vld = count != '0;
  assign head_cmd = mem[rd_ptr];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end
    else
    begin
      // one credit back per entry that leaves
      credit <= pop;
      if (cmd_vld)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop)
        rd_ptr <= next_ptr(rd_ptr);
      case ({cmd_vld, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_vld)
      mem[wr_ptr] <= cmd;
  end

  // host must hold a credit, arbiter must see a head
  a_push_not_full: assert property (@(posedge clk) disable iff (!rst_n) cmd_vld |-> !full);
  a_pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> head_vld);

endmodule

`default_nettype wire

/* design/link_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module link_arbiter (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               head_vld0,
  input  logic                               head_vld1,
  input  logic [uart_link_pkg::CMD_WIDTH-1:0] head_cmd0,
  input  logic [uart_link_pkg::CMD_WIDTH-1:0] head_cmd1,
  input  logic                               idle,
  output logic                               pop0,
  output logic                               pop1,
  output logic                               start,
  output logic [uart_link_pkg::CMD_WIDTH-1:0] start_cmd,
  output logic                               grant_port
);

  logic prio;
  logic can_grant;

  // engine still reads idle while start is in flight
  assign can_grant = idle && !start;

  // prio high means port 1 wins a tie
  assign pop0 = can_grant && head_vld0 && (!head_vld1 || !prio);
  assign pop1 = can_grant && head_vld1 && (!head_vld0 || prio);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      prio       <= 1'b0;
      start      <= 1'b0;
      grant_port <= 1'b0;
    end
    else
    begin
      start <= pop0 || pop1;
      if (pop0 || pop1)
      begin
        prio       <= pop0;
        grant_port <= pop1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (pop0 || pop1)
      start_cmd <= pop1 ? head_cmd1 : head_cmd0;
  end

  a_one_pop: assert property (@(posedge clk) disable iff (!rst_n) !(pop0 && pop1));

endmodule

`default_nettype wire

/* design/uart_tx_frame.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx_frame #(
  parameter int BAUD_DIV = 434
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                send,
  input  logic [uart_link_pkg::DATA_WIDTH-1:0] tx_byte,
  output logic                                tx,
  output logic                                tx_done
);

  localparam int CNT_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;
  localparam int BIT_W = $clog2(uart_link_pkg::DATA_WIDTH);

  uart_link_pkg::tx_state_e             state;
  logic [CNT_W-1:0]                     baud_cnt;
  logic [BIT_W-1:0]                     bit_cnt;
  logic [uart_link_pkg::DATA_WIDTH-1:0] shift_reg;
  logic                                 parity_bit;
  logic                                 baud_last;

  assign baud_last = baud_cnt == CNT_W'(BAUD_DIV - 1);
  assign tx_done   = (state == uart_link_pkg::TX_STOP) && baud_last;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= uart_link_pkg::TX_IDLE;
      tx       <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end
    else
    begin
      baud_cnt <= (state == uart_link_pkg::TX_IDLE || baud_last) ? '0 : baud_cnt + 1'b1;
      case (state)
        uart_link_pkg::TX_IDLE:
          if (send)
          begin
            state <= uart_link_pkg::TX_START;
            tx    <= 1'b0;
          end
        uart_link_pkg::TX_START:
          if (baud_last)
          begin
            state   <= uart_link_pkg::TX_DATA;
            tx      <= shift_reg[0];
            bit_cnt <= '0;
          end
        uart_link_pkg::TX_DATA:
          if (baud_last)
          begin
            if (bit_cnt == BIT_W'(uart_link_pkg::DATA_WIDTH - 1))
            begin
              state <= uart_link_pkg::TX_PARITY;
              tx    <= parity_bit;
            end
            else
            begin
              bit_cnt <= bit_cnt + 1'b1;
              tx      <= shift_reg[1];
            end
          end
        uart_link_pkg::TX_PARITY:
          if (baud_last)
          begin
            state <= uart_link_pkg::TX_STOP;
            tx    <= 1'b1;
          end
        uart_link_pkg::TX_STOP:
          if (baud_last)
            state <= uart_link_pkg::TX_IDLE;
        default:
          state <= uart_link_pkg::TX_IDLE;
      endcase
    end
  end

  // lsb first, even parity
  always_ff @(posedge clk)
  begin
    if (send && state == uart_link_pkg::TX_IDLE)
    begin
      shift_reg  <= tx_byte;
      parity_bit <= ^tx_byte;
    end
    else if (state == uart_link_pkg::TX_DATA && baud_last)
      shift_reg <= shift_reg >> 1;
  end

  a_send_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    send |-> state == uart_link_pkg::TX_IDLE);

endmodule

`default_nettype wire

/* design/uart_rx_frame.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx_frame #(
  parameter int BAUD_DIV          = 434,
  parameter int RESP_TIMEOUT_BITS = 24
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                arm,
  input  logic                                rx,
  output logic [uart_link_pkg::DATA_WIDTH-1:0] rx_byte,
  output logic                                parity_err,
  output logic                                rx_done,
  output logic                                rx_timeout
);

  localparam int HALF       = BAUD_DIV / 2;
  localparam int TMO_CYCLES = RESP_TIMEOUT_BITS * BAUD_DIV;
  localparam int CNT_W      = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;
  localparam int TMO_W      = (TMO_CYCLES > 1) ? $clog2(TMO_CYCLES) : 1;
  localparam int BIT_W      = $clog2(uart_link_pkg::DATA_WIDTH + 1);

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_HUNT,
    RX_START,
    RX_BITS,
    RX_STOP
  } rx_state_e;

  rx_state_e        state;
  logic             rx_meta;
  logic             rx_sync;
  logic [CNT_W-1:0] baud_cnt;
  logic [TMO_W-1:0] tmo_cnt;
  logic [BIT_W-1:0] bit_cnt;
  logic             par_bit;
  logic             baud_last;
  logic             half_last;
  logic             tmo_last;

  assign baud_last  = baud_cnt == CNT_W'(BAUD_DIV - 1);
  assign half_last  = baud_cnt == CNT_W'(HALF - 1);
  assign tmo_last   = tmo_cnt == TMO_W'(TMO_CYCLES - 1);
  assign rx_done    = (state == RX_STOP) && baud_last;
  assign rx_timeout = (state == RX_HUNT) && rx_sync && tmo_last;
  assign parity_err = (^rx_byte) ^ par_bit;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= RX_IDLE;
      baud_cnt <= '0;
      tmo_cnt  <= '0;
      bit_cnt  <= '0;
    end
    else
    begin
      case (state)
        RX_IDLE:
          if (arm)
          begin
            state   <= RX_HUNT;
            tmo_cnt <= '0;
          end
        RX_HUNT:
          if (!rx_sync)
          begin
            state    <= RX_START;
            baud_cnt <= '0;
          end
          else if (tmo_last)
            state <= RX_IDLE;
          else
            tmo_cnt <= tmo_cnt + 1'b1;
        RX_START:
          // mid start bit, a high level here was a glitch
          if (half_last)
          begin
            state    <= rx_sync ? RX_HUNT : RX_BITS;
            baud_cnt <= '0;
            bit_cnt  <= '0;
          end
          else
            baud_cnt <= baud_cnt + 1'b1;
        RX_BITS:
          if (baud_last)
          begin
            baud_cnt <= '0;
            if (bit_cnt == BIT_W'(uart_link_pkg::DATA_WIDTH))
              state <= RX_STOP;
            else
              bit_cnt <= bit_cnt + 1'b1;
          end
          else
            baud_cnt <= baud_cnt + 1'b1;
        RX_STOP:
          if (baud_last)
            state <= RX_IDLE;
          else
            baud_cnt <= baud_cnt + 1'b1;
        default:
          state <= RX_IDLE;
      endcase
    end
  end

  // eight data samples then the parity sample
  always_ff @(posedge clk)
  begin
    if (state == RX_BITS && baud_last)
    begin
      if (bit_cnt == BIT_W'(uart_link_pkg::DATA_WIDTH))
        par_bit <= rx_sync;
      else
        rx_byte <= {rx_sync, rx_byte[uart_link_pkg::DATA_WIDTH-1:1]};
    end
  end

  a_arm_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    arm |-> state == RX_IDLE);

endmodule

`default_nettype wire

/* design/uart_cmd_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_engine #(
  parameter int BAUD_DIV = 434,
  parameter int GAP_BITS = 2
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                start,
  input  logic [uart_link_pkg::CMD_WIDTH-1:0]  start_cmd,
  input  logic                                grant_port,
  output logic                                idle,
  output logic                                send,
  output logic [uart_link_pkg::DATA_WIDTH-1:0] tx_byte,
  input  logic                                tx_done,
  output logic                                arm,
  input  logic [uart_link_pkg::DATA_WIDTH-1:0] rx_byte,
  input  logic                                parity_err,
  input  logic                                rx_done,
  input  logic                                rx_timeout,
  output logic                                port0_resp_vld,
  output logic                                port1_resp_vld,
  output logic [uart_link_pkg::DATA_WIDTH-1:0] resp_data,
  output logic                                resp_err
);

  localparam int GAP_CYCLES = GAP_BITS * BAUD_DIV;
  localparam int GAP_W      = (GAP_CYCLES > 1) ? $clog2(GAP_CYCLES) : 1;
  localparam int OP_BIT     = uart_link_pkg::CMD_WIDTH - 1;

  uart_link_pkg::engine_state_e         state;
  uart_link_pkg::cmd_op_e               op_q;
  logic                                 port_q;
  logic [uart_link_pkg::DATA_WIDTH-1:0] data_q;
  logic [GAP_W-1:0]                     gap_cnt;
  logic                                 gap_last;
  logic                                 is_read;

  assign idle     = state == uart_link_pkg::ENG_IDLE;
  assign gap_last = gap_cnt == GAP_W'(GAP_CYCLES - 1);
  assign is_read  = op_q == uart_link_pkg::OP_READ;

  // ##########################################################################
  // framer handshakes
  // ##########################################################################
  // high frame leaves with start, low frame on the last gap cycle
  assign send = (idle && start) || (state == uart_link_pkg::ENG_GAP && gap_last);
  assign arm  = (state == uart_link_pkg::ENG_SEND_HI) && tx_done && is_read;

  // op and address form the high byte
  always_comb
  begin
    if (idle)
      tx_byte = {start_cmd[OP_BIT],
                 start_cmd[uart_link_pkg::DATA_WIDTH +: uart_link_pkg::ADDR_WIDTH]};
    else
      tx_byte = data_q;
  end

  assign port0_resp_vld = (state == uart_link_pkg::ENG_RESPOND) && !port_q;
  assign port1_resp_vld = (state == uart_link_pkg::ENG_RESPOND) && port_q;

  // ##########################################################################
  // transaction sequencing
  // ##########################################################################
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= uart_link_pkg::ENG_IDLE;
      op_q    <= uart_link_pkg::OP_READ;
      port_q  <= 1'b0;
      gap_cnt <= '0;
    end
    else
    begin
      case (state)
        uart_link_pkg::ENG_IDLE:
          if (start)
          begin
            state  <= uart_link_pkg::ENG_SEND_HI;
            op_q   <= uart_link_pkg::cmd_op_e'(start_cmd[OP_BIT]);
            port_q <= grant_port;
          end
        uart_link_pkg::ENG_SEND_HI:
          if (tx_done)
          begin
            gap_cnt <= '0;
            state   <= is_read ? uart_link_pkg::ENG_WAIT_RESP : uart_link_pkg::ENG_GAP;
          end
        uart_link_pkg::ENG_GAP:
          if (gap_last)
            state <= uart_link_pkg::ENG_SEND_LO;
          else
            gap_cnt <= gap_cnt + 1'b1;
        uart_link_pkg::ENG_SEND_LO:
          if (tx_done)
            state <= uart_link_pkg::ENG_IDLE;
        uart_link_pkg::ENG_WAIT_RESP:
          if (rx_done || rx_timeout)
            state <= uart_link_pkg::ENG_RESPOND;
        uart_link_pkg::ENG_RESPOND:
          state <= uart_link_pkg::ENG_IDLE;
        default:
          state <= uart_link_pkg::ENG_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (idle && start)
      data_q <= start_cmd[uart_link_pkg::DATA_WIDTH-1:0];
    // silent device reads back as zero with error
    if (state == uart_link_pkg::ENG_WAIT_RESP && (rx_done || rx_timeout))
    begin
      resp_data <= rx_timeout ? '0 : rx_byte;
      resp_err  <= rx_timeout || parity_err;
    end
  end

  // arbiter holds off while a transaction owns the link
  a_start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    start |-> state == uart_link_pkg::ENG_IDLE);

endmodule

`default_nettype wire

/* design/uart_bridge_top.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_bridge_top #(
  parameter int BAUD_DIV          = 434,
  parameter int GAP_BITS          = 2,
  parameter int RESP_TIMEOUT_BITS = 24,
  parameter int QUEUE_DEPTH       = 4
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                port0_cmd_vld,
  input  logic                                port1_cmd_vld,
  input  logic [uart_link_pkg::CMD_WIDTH-1:0]  port0_cmd,
  input  logic [uart_link_pkg::CMD_WIDTH-1:0]  port1_cmd,
  output logic                                port0_credit,
  output logic                                port1_credit,
  output logic                                port0_resp_vld,
  output logic                                port1_resp_vld,
  output logic [uart_link_pkg::DATA_WIDTH-1:0] resp_data,
  output logic                                resp_err,
  output logic                                tx,
  input  logic                                rx
);

  logic                                 head_vld0;
  logic                                 head_vld1;
  logic [uart_link_pkg::CMD_WIDTH-1:0]  head_cmd0;
  logic [uart_link_pkg::CMD_WIDTH-1:0]  head_cmd1;
  logic                                 pop0;
  logic                                 pop1;
  logic                                 idle;
  logic                                 start;
  logic [uart_link_pkg::CMD_WIDTH-1:0]  start_cmd;
  logic                                 grant_port;
  logic                                 send;
  logic [uart_link_pkg::DATA_WIDTH-1:0] tx_byte;
  logic                                 tx_done;
  logic                                 arm;
  logic [uart_link_pkg::DATA_WIDTH-1:0] rx_byte;
  logic                                 parity_err;
  logic                                 rx_done;
  logic                                 rx_timeout;

  cmd_port #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_port0 (
    .clk(clk), .rst_n(rst_n), .cmd_vld(port0_cmd_vld), .cmd(port0_cmd), .pop(pop0),
    .credit(port0_credit), .head_vld(head_vld0), .head_cmd(head_cmd0)
  );

  cmd_port #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_port1 (
    .clk(clk), .rst_n(rst_n), .cmd_vld(port1_cmd_vld), .cmd(port1_cmd), .pop(pop1),
    .credit(port1_credit), .head_vld(head_vld1), .head_cmd(head_cmd1)
  );

  link_arbiter u_link_arbiter (
    .clk(clk), .rst_n(rst_n), .head_vld0(head_vld0), .head_vld1(head_vld1),
    .head_cmd0(head_cmd0), .head_cmd1(head_cmd1), .idle(idle), .pop0(pop0), .pop1(pop1),
    .start(start), .start_cmd(start_cmd), .grant_port(grant_port)
  );

  uart_cmd_engine #(.BAUD_DIV(BAUD_DIV), .GAP_BITS(GAP_BITS)) u_uart_cmd_engine (
    .clk(clk), .rst_n(rst_n), .start(start), .start_cmd(start_cmd),
    .grant_port(grant_port), .idle(idle), .send(send), .tx_byte(tx_byte),
    .tx_done(tx_done), .arm(arm), .rx_byte(rx_byte), .parity_err(parity_err),
    .rx_done(rx_done), .rx_timeout(rx_timeout), .port0_resp_vld(port0_resp_vld),
    .port1_resp_vld(port1_resp_vld), .resp_data(resp_data), .resp_err(resp_err)
  );

  uart_tx_frame #(.BAUD_DIV(BAUD_DIV)) u_uart_tx_frame (
    .clk(clk), .rst_n(rst_n), .send(send), .tx_byte(tx_byte), .tx(tx), .tx_done(tx_done)
  );

  uart_rx_frame #(
    .BAUD_DIV(BAUD_DIV),
    .RESP_TIMEOUT_BITS(RESP_TIMEOUT_BITS)
  ) u_uart_rx_frame (
    .clk(clk), .rst_n(rst_n), .arm(arm), .rx(rx), .rx_byte(rx_byte),
    .parity_err(parity_err), .rx_done(rx_done), .rx_timeout(rx_timeout)
  );

endmodule

`default_nettype wire

/* bench/uart_device_model.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_device_model #(
  parameter int BAUD_DIV = 8
) (
  input  logic clk,
  input  logic tx,
  output logic rx
);

  localparam int DW = uart_link_pkg::DATA_WIDTH;
  localparam int AW = uart_link_pkg::ADDR_WIDTH;

  logic [DW-1:0]            mem [2**AW];
  int                       frame_errs;
  int                       collisions;
  uart_link_pkg::tx_state_e drive_state;
  logic [DW-1:0]            frame_byte;
  logic                     expect_lo;
  logic [AW-1:0]            wr_addr;

  // one frame from tx sampled mid-bit on the falling edge
  task automatic take_frame();
    logic par;
    logic stop;
    while (tx !== 1'b1)
      @(negedge clk);
    while (tx !== 1'b0)
      @(negedge clk);
    repeat (BAUD_DIV / 2) @(negedge clk);
    for (int i = 0; i < DW; i++)
    begin
      repeat (BAUD_DIV) @(negedge clk);
      frame_byte[i] = tx;
    end
    repeat (BAUD_DIV) @(negedge clk);
    par = tx;
    repeat (BAUD_DIV) @(negedge clk);
    stop = tx;
    if (par !== ^frame_byte || stop !== 1'b1)
      frame_errs++;
  endtask

  task automatic drive_bit(input logic value);
    @(posedge clk);
    #2;
    rx = value;
    repeat (BAUD_DIV - 1) @(posedge clk);
  endtask

  task automatic answer_read(input logic [AW-1:0] addr);
    logic [DW-1:0] value;
    logic          par;
    value = mem[addr];
    par   = ^value;
    // broken parity on purpose
    if (addr == 7'h55)
      par = ~par;
    repeat (3 * BAUD_DIV) @(posedge clk);
    drive_state = uart_link_pkg::TX_START;
    drive_bit(1'b0);
    drive_state = uart_link_pkg::TX_DATA;
    for (int i = 0; i < DW; i++)
      drive_bit(value[i]);
    drive_state = uart_link_pkg::TX_PARITY;
    drive_bit(par);
    // idle high line doubles as the stop bit
    drive_state = uart_link_pkg::TX_STOP;
    @(posedge clk);
    #2;
    rx = 1'b1;
    drive_state = uart_link_pkg::TX_IDLE;
  endtask

  // tx must stay idle while a response goes out
  always @(negedge clk)
  begin
    if (drive_state != uart_link_pkg::TX_IDLE && tx !== 1'b1)
      collisions++;
  end

  initial
  begin
    for (int a = 0; a < 2**AW; a++)
      mem[a] = '0;
    frame_errs  = 0;
    collisions  = 0;
    expect_lo   = 1'b0;
    wr_addr     = '0;
    drive_state = uart_link_pkg::TX_IDLE;
    rx          = 1'b1;
    forever
    begin
      take_frame();
      if (expect_lo)
      begin
        mem[wr_addr] = frame_byte;
        expect_lo    = 1'b0;
      end
      else if (frame_byte[DW-1])
      begin
        wr_addr   = frame_byte[AW-1:0];
        expect_lo = 1'b1;
      end
      // 0x7F never answers
      else if (frame_byte[AW-1:0] != 7'h7F)
        answer_read(frame_byte[AW-1:0]);
    end
  end

endmodule

`default_nettype wire

/* bench/tb_uart_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_uart_bridge;

  localparam int BAUD_DIV       = 8;
  localparam int QUEUE_DEPTH    = 4;
  localparam int DW             = uart_link_pkg::DATA_WIDTH;
  localparam int CW             = uart_link_pkg::CMD_WIDTH;
  localparam int MEM_SIZE       = 2 ** uart_link_pkg::ADDR_WIDTH;
  localparam int NUM_RAND       = 40;
  localparam int CREDIT_TIMEOUT = 5000;
  localparam int DRAIN_TIMEOUT  = 20000;
  localparam int QUIET_CYCLES   = 4 * BAUD_DIV;

  logic          clk;
  logic          rst_n;
  logic          port0_cmd_vld;
  logic          port1_cmd_vld;
  logic [CW-1:0] port0_cmd;
  logic [CW-1:0] port1_cmd;
  logic          port0_credit;
  logic          port1_credit;
  logic          port0_resp_vld;
  logic          port1_resp_vld;
  logic [DW-1:0] resp_data;
  logic          resp_err;
  logic          tx;
  logic          rx;

  int            seed;
  int            data_errs;
  int            flag_errs;
  int            count_errs;
  int            other_errs;
  int            credits [2];
  int            issued [2];
  int            credit_pulses [2];
  int            resp_seen;
  logic [DW-1:0] ref_mem [MEM_SIZE];
  // {addr, err, data} per outstanding read
  logic [CW-1:0] exp_q0 [$];
  logic [CW-1:0] exp_q1 [$];
  logic [CW-1:0] rand_cmd [2][NUM_RAND];
  int            rand_gap [2][NUM_RAND];

  uart_bridge_top #(
    .BAUD_DIV(BAUD_DIV),
    .GAP_BITS(2),
    .RESP_TIMEOUT_BITS(24),
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) u_uart_bridge_top (
    .clk(clk), .rst_n(rst_n), .port0_cmd_vld(port0_cmd_vld), .port1_cmd_vld(port1_cmd_vld),
    .port0_cmd(port0_cmd), .port1_cmd(port1_cmd), .port0_credit(port0_credit),
    .port1_credit(port1_credit), .port0_resp_vld(port0_resp_vld),
    .port1_resp_vld(port1_resp_vld), .resp_data(resp_data), .resp_err(resp_err),
    .tx(tx), .rx(rx)
  );

  uart_device_model #(.BAUD_DIV(BAUD_DIV)) u_device (.clk(clk), .tx(tx), .rx(rx));

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ##########################################################################
  // compare tasks
  // ##########################################################################
  task automatic check_data(input string name, input logic [DW-1:0] expected,
                            input logic [DW-1:0] actual);
    if (actual !== expected)
    begin
      data_errs++;
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      flag_errs++;
      $display("Fail %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic match_count(input string name, input int expected, input int actual);
    if (actual != expected)
    begin
      count_errs++;
      $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  // ##########################################################################
  // host side and reference model
  // ##########################################################################
  task automatic expect_read(input int port, input logic [6:0] addr);
    logic          err;
    logic [DW-1:0] data;
    // bad parity at 0x55 and no answer at 0x7F
    err  = (addr == 7'h55) || (addr == 7'h7F);
    data = (addr == 7'h7F) ? '0 : ref_mem[addr];
    if (port == 0)
      exp_q0.push_back({addr, err, data});
    else
      exp_q1.push_back({addr, err, data});
  endtask

  task automatic issue_cmd(input int port, input logic [CW-1:0] cmd);
    @(posedge clk);
    #2;
    if (port == 0)
    begin
      port0_cmd_vld = 1'b1;
      port0_cmd     = cmd;
    end
    else
    begin
      port1_cmd_vld = 1'b1;
      port1_cmd     = cmd;
    end
    credits[port]--;
    issued[port]++;
    // reference memory follows each port's issue order
    if (cmd[CW-1])
      ref_mem[cmd[14:8]] = cmd[DW-1:0];
    else
      expect_read(port, cmd[14:8]);
    @(posedge clk);
    #2;
    if (port == 0)
      port0_cmd_vld = 1'b0;
    else
      port1_cmd_vld = 1'b0;
  endtask

  task automatic await_credit(input int port, output logic ok);
    int waited;
    waited = 0;
    while (credits[port] == 0 && waited < CREDIT_TIMEOUT)
    begin
      @(posedge clk);
      waited++;
    end
    ok = credits[port] != 0;
    if (!ok)
    begin
      other_errs++;
      $display("Error: port %0d got no credit back within %0d cycles", port, waited);
    end
  endtask

  task automatic submit(input int port, input logic [CW-1:0] cmd);
    logic ok;
    await_credit(port, ok);
    if (ok)
      issue_cmd(port, cmd);
  endtask

  task automatic run_host(input int port);
    for (int i = 0; i < NUM_RAND; i++)
    begin
      repeat (rand_gap[port][i]) @(posedge clk);
      submit(port, rand_cmd[port][i]);
    end
  endtask

  task automatic make_traffic();
    logic [31:0] word;
    logic [6:0]  addr;
    for (int p = 0; p < 2; p++)
      for (int i = 0; i < NUM_RAND; i++)
      begin
        word = $random(seed);
        // port 0 owns 0..63 and port 1 owns 64..126
        if (p == 0)
          addr = {1'b0, word[13:8]};
        else
          addr = 7'(64 + word[14:8] % 63);
        rand_cmd[p][i] = {word[31], addr, word[7:0]};
        rand_gap[p][i] = int'(word[25:24]);
      end
  endtask

  task automatic take_response(input int port);
    logic [CW-1:0] exp;
    resp_seen++;
    if ((port == 0 && exp_q0.size() == 0) || (port == 1 && exp_q1.size() == 0))
    begin
      other_errs++;
      $display("Error: response on port %0d with no read outstanding", port);
    end
    else
    begin
      if (port == 0)
        exp = exp_q0.pop_front();
      else
        exp = exp_q1.pop_front();
      check_data($sformatf("port%0d read 0x%h data", port, exp[15:9]), exp[DW-1:0], resp_data);
      check_flag($sformatf("port%0d read 0x%h err", port, exp[15:9]), exp[DW], resp_err);
    end
  endtask

  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (port0_credit)
      begin
        credits[0]++;
        credit_pulses[0]++;
      end
      if (port1_credit)
      begin
        credits[1]++;
        credit_pulses[1]++;
      end
      if (port0_resp_vld)
        take_response(0);
      if (port1_resp_vld)
        take_response(1);
    end
  end

  function automatic bit link_drained();
    return exp_q0.size() == 0 && exp_q1.size() == 0 &&
           credits[0] == QUEUE_DEPTH && credits[1] == QUEUE_DEPTH;
  endfunction

  // all reads answered, all credits home, then tx idle for a while
  task automatic drain_link();
    int waited;
    int quiet;
    waited = 0;
    while (!link_drained() && waited < DRAIN_TIMEOUT)
    begin
      @(negedge clk);
      waited++;
    end
    if (!link_drained())
    begin
      other_errs++;
      $display("Error: reads or credits still outstanding after %0d cycles", waited);
    end
    waited = 0;
    quiet  = 0;
    while (quiet < QUIET_CYCLES && waited < DRAIN_TIMEOUT)
    begin
      @(negedge clk);
      waited++;
      quiet = (tx === 1'b1) ? quiet + 1 : 0;
    end
    if (quiet < QUIET_CYCLES)
    begin
      other_errs++;
      $display("Error: tx line never went idle after the last command");
    end
  endtask

  // ##########################################################################
  // test sequence
  // ##########################################################################
  initial
  begin
    int total;
    seed          = 93;
    data_errs     = 0;
    flag_errs     = 0;
    count_errs    = 0;
    other_errs    = 0;
    resp_seen     = 0;
    port0_cmd_vld = 1'b0;
    port1_cmd_vld = 1'b0;
    port0_cmd     = '0;
    port1_cmd     = '0;
    rst_n         = 1'b0;
    for (int p = 0; p < 2; p++)
    begin
      credits[p]       = QUEUE_DEPTH;
      issued[p]        = 0;
      credit_pulses[p] = 0;
    end
    for (int a = 0; a < MEM_SIZE; a++)
      ref_mem[a] = '0;
    make_traffic();
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // quiet link after reset
    repeat (50)
    begin
      @(negedge clk);
      check_flag("tx level after reset", 1'b1, tx);
    end
    match_count("credit pulses after reset", 0, credit_pulses[0] + credit_pulses[1]);
    match_count("responses after reset", 0, resp_seen);

    // write then read back, then the two error addresses
    submit(0, {1'b1, 7'h05, 8'hA5});
    submit(0, {1'b0, 7'h05, 8'h00});
    submit(1, {1'b1, 7'h64, 8'h3C});
    submit(1, {1'b0, 7'h64, 8'h00});
    submit(0, {1'b0, 7'h55, 8'h00});
    submit(0, {1'b0, 7'h7F, 8'h00});
    drain_link();

    fork
      run_host(0);
      run_host(1);
    join
    drain_link();

    for (int p = 0; p < 2; p++)
    begin
      match_count($sformatf("port%0d credit pulses", p), issued[p], credit_pulses[p]);
      match_count($sformatf("port%0d credits held", p), QUEUE_DEPTH, credits[p]);
    end
    match_count("bad frames on tx", 0, u_device.frame_errs);
    match_count("tx activity during a response", 0, u_device.collisions);
    for (int a = 0; a < MEM_SIZE; a++)
      check_data($sformatf("device memory 0x%h", 7'(a)), ref_mem[a], u_device.mem[a]);

    total = data_errs + flag_errs + count_errs + other_errs;
    $display("error counts: data %0d, flag %0d, count %0d, other %0d",
             data_errs, flag_errs, count_errs, other_errs);
    if (total == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
design/uart_link_pkg.sv
design/cmd_port.sv
design/link_arbiter.sv
design/uart_tx_frame.sv
design/uart_rx_frame.sv
design/uart_cmd_engine.sv
design/uart_bridge_top.sv
bench/uart_device_model.sv
bench/tb_uart_bridge.sv

/* run_sim.sh */
#!/bin/sh
# verilator build and run of tb_uart_bridge

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_uart_bridge -f compile.f -o tb_uart_bridge
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_uart_bridge > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulator exited with status $run_status"
  exit 1
fi

if grep -qx "Simulation passed" "$LOG"; then
  exit 0
fi
exit 1
